// File: files.f
src/kernel_pkg.sv
src/payload_fifo.sv
src/host_regs.sv
src/axi_write_master.sv
src/axi_read_master.sv
src/kernel.sv
verification/kernel_asserts.sv
verification/kernel_tb.sv

// File: verification/kernel_tb.sv
`timescale 1ns/100ps

module kernel_tb;

  import kernel_pkg::*;

  logic                   clk;
  logic                   rstn;
  logic                   link_rstn;
  logic                   host_en;
  logic [3:0]             host_we;
  logic [HOST_ADDR_W-1:0] host_addr;
  logic [HOST_DATA_W-1:0] host_din;
  logic [HOST_DATA_W-1:0] host_dout;
  logic [AXI_ADDR_W-1:0]  k2o_awaddr;
  logic [AXI_ADDR_W-1:0]  k2o_araddr;
  logic [2:0]             k2o_awsize;
  logic [2:0]             k2o_arsize;
  logic [AXI_ID_W-1:0]    k2o_awid;
  logic [AXI_ID_W-1:0]    k2o_arid;
  logic [AXI_ID_W-1:0]    k2o_bid;
  logic [AXI_ID_W-1:0]    k2o_rid;
  logic [7:0]             k2o_awlen;
  logic [7:0]             k2o_arlen;
  logic [1:0]             k2o_awburst;
  logic [1:0]             k2o_arburst;
  logic [1:0]             k2o_bresp;
  logic [1:0]             k2o_rresp;
  logic                   k2o_awvalid;
  logic                   k2o_awready;
  logic                   k2o_wvalid;
  logic                   k2o_wready;
  logic                   k2o_arvalid;
  logic                   k2o_arready;
  logic                   k2o_bvalid;
  logic                   k2o_bready;
  logic                   k2o_rvalid;
  logic                   k2o_rready;
  logic                   k2o_rlast;
  logic                   k2o_wlast;
  logic [AXI_DATA_W-1:0]  k2o_wdata;
  logic [AXI_DATA_W-1:0]  k2o_rdata;
  logic [AXI_STRB_W-1:0]  k2o_wstrb;

  logic [31:0]  model_stage [8];
  logic [5:0]   b_model [$]; // {id, resp} held in the B queue
  logic [133:0] r_model [$];
  logic [159:0] got_aw [$];
  logic [159:0] got_w [$];
  logic [159:0] got_ar [$];
  logic [159:0] exp_aw [$];
  logic [159:0] exp_w [$];
  string        chk_name [$];
  logic [159:0] chk_exp [$];
  logic [159:0] chk_act [$];
  string        cur_name;
  logic [159:0] cur_exp;
  logic [159:0] cur_act;

  kernel #(.fifo_log2_depth(2)) kernel_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // slave side readiness
  always @(posedge clk) begin
    #2;
    k2o_awready = $urandom_range(0, 1);
    k2o_wready  = $urandom_range(0, 1);
    k2o_arready = $urandom_range(0, 1);
  end

  // valid and ready settle before the edge that completes the beat
  always @(negedge clk) begin
    if (k2o_awvalid && k2o_awready) begin
      got_aw.push_back({k2o_awburst, k2o_awid, k2o_awsize, k2o_awaddr});
    end
    if (k2o_wvalid && k2o_wready) begin
      got_w.push_back({k2o_wstrb, k2o_wdata});
    end
    if (k2o_arvalid && k2o_arready) begin
      got_ar.push_back({k2o_arburst, k2o_arid, k2o_arsize, k2o_araddr});
    end
  end

  always @(negedge clk) begin
    while (chk_name.size() > 0) begin
      cur_name = chk_name.pop_front();
      cur_exp  = chk_exp.pop_front();
      cur_act  = chk_act.pop_front();
      assert (cur_act === cur_exp) else begin
        $display("ERR %s expected %h actual %h", cur_name, cur_exp, cur_act);
        $display("ERRORS FOUND");
        $fatal(1, "value mismatch");
      end
    end
  end

  always @(negedge clk) begin
    if (kernel_i.kernel_asserts_i.assert_fails != 0) begin
      $display("a bound assertion on the AXI master outputs failed");
      $display("ERRORS FOUND");
      $fatal(1, "assertion failure");
    end
  end

  // host-visible word as the register map defines it
  function automatic logic [31:0] expect_word(input logic [HOST_ADDR_W-1:0] addr);
    if (addr < 15'h020 && addr[1:0] == 2'b00) return model_stage[addr[4:2]];
    if (addr == REG_B_STATUS) return {31'b0, b_model.size() != 0};
    if (addr == REG_R_STATUS) return {31'b0, r_model.size() != 0};
    return 32'h0;
  endfunction

  task automatic push_check(input string name, input logic [159:0] exp, input logic [159:0] act);
    chk_name.push_back(name);
    chk_exp.push_back(exp);
    chk_act.push_back(act);
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("ERRORS FOUND");
    $fatal(1, "stopped on timeout");
  endtask

  task automatic host_write(input logic [HOST_ADDR_W-1:0] addr, input logic [31:0] data);
    host_en   = 1'b1;
    host_we   = 4'hf;
    host_addr = addr;
    host_din  = data;
    @(posedge clk);
    #2;
    host_en = 1'b0;
    host_we = 4'h0;
    if (addr < 15'h020) model_stage[addr[4:2]] = data;
  endtask

  task automatic check_word(input string name, input logic [HOST_ADDR_W-1:0] addr);
    host_en   = 1'b1;
    host_we   = 4'h0;
    host_addr = addr;
    @(posedge clk);
    #2;
    host_en = 1'b0;
    push_check(name, expect_word(addr), host_dout); // one cycle latency
  endtask

  task automatic check_all_words(input string name);
    for (int i = 0; i < 8; i++) check_word($sformatf("%s word %0d", name, i), 15'(4 * i));
  endtask

  task automatic fill_words(input int count);
    for (int i = 0; i < count; i++) host_write(15'(4 * i), $urandom());
  endtask

  task automatic wait_link(input logic level, input int limit);
    int n;
    n = 0;
    while (link_rstn !== level) begin
      if (n == limit) report_timeout("link_rstn");
      @(posedge clk);
      #2;
      n++;
    end
  endtask

  task automatic send_b(input logic [3:0] id, input logic [1:0] resp);
    int n;
    n = 0;
    k2o_bid    = id;
    k2o_bresp  = resp;
    k2o_bvalid = 1'b1;
    while (k2o_bready !== 1'b1) begin
      if (n == 200) report_timeout("bready");
      @(posedge clk);
      #2;
      n++;
    end
    @(posedge clk);
    #2;
    k2o_bvalid = 1'b0;
    b_model.push_back({id, resp});
  endtask

  task automatic send_r(input logic [127:0] data, input logic [3:0] id, input logic [1:0] resp);
    int n;
    n = 0;
    k2o_rdata  = data;
    k2o_rid    = id;
    k2o_rresp  = resp;
    k2o_rlast  = 1'b1;
    k2o_rvalid = 1'b1;
    while (k2o_rready !== 1'b1) begin
      if (n == 200) report_timeout("rready");
      @(posedge clk);
      #2;
      n++;
    end
    @(posedge clk);
    #2;
    k2o_rvalid = 1'b0;
    r_model.push_back({id, resp, data});
  endtask

  task automatic pop_b();
    logic [5:0] entry;
    entry = b_model.pop_front();
    host_write(REG_B_POP, 32'h0);
    for (int i = 0; i < 8; i++) model_stage[i] = 32'h0; // zero extended
    model_stage[0] = {26'b0, entry};
  endtask

  task automatic pop_r();
    logic [133:0] entry;
    entry = r_model.pop_front();
    host_write(REG_R_POP, 32'h0);
    for (int i = 0; i < 8; i++) model_stage[i] = 32'h0;
    for (int i = 0; i < 4; i++) model_stage[i] = entry[32 * i +: 32];
    model_stage[4] = {26'b0, entry[133:128]};
  endtask

  initial begin
    int n;
    void'($urandom(1));
    rstn = 1'b0;
    host_en = 1'b0;
    host_we = 4'h0;
    host_addr = '0;
    host_din = '0;
    k2o_awready = 1'b0;
    k2o_wready = 1'b0;
    k2o_arready = 1'b0;
    k2o_bid = '0;
    k2o_bresp = '0;
    k2o_bvalid = 1'b0;
    k2o_rdata = '0;
    k2o_rid = '0;
    k2o_rresp = '0;
    k2o_rlast = 1'b0;
    k2o_rvalid = 1'b0;
    repeat (3) @(posedge clk);
    #2;
    rstn = 1'b1;

    push_check("reset awvalid", 0, k2o_awvalid);
    push_check("reset wvalid", 0, k2o_wvalid);
    push_check("reset arvalid", 0, k2o_arvalid);
    push_check("reset bready", 1, k2o_bready);
    push_check("reset rready", 1, k2o_rready);
    wait_link(1'b1, 2);

    fill_words(8);
    check_all_words("staging");

    for (int k = 0; k < 3; k++) begin
      fill_words(5);
      exp_aw.push_back({2'b01, 4'd1, model_stage[2][2:0], model_stage[1], model_stage[0]});
      exp_w.push_back({model_stage[4][15:0], model_stage[3], model_stage[2],
                       model_stage[1], model_stage[0]});
      host_write(REG_AW_PUSH, 32'h0);
      host_write(REG_W_PUSH, 32'h0);
    end
    n = 0;
    while (got_aw.size() < 3 || got_w.size() < 3) begin
      if (n == 200) report_timeout("aw and w handshakes");
      @(posedge clk);
      #2;
      n++;
    end
    for (int k = 0; k < 3; k++) begin
      push_check($sformatf("aw beat %0d", k), exp_aw.pop_front(), got_aw.pop_front());
      push_check($sformatf("w beat %0d", k), exp_w.pop_front(), got_w.pop_front());
    end

    for (int k = 0; k < 3; k++) send_b($urandom_range(0, 15), $urandom_range(0, 3));
    for (int k = 0; k < 3; k++) begin
      check_word($sformatf("b status %0d", k), REG_B_STATUS);
      pop_b();
      check_all_words($sformatf("b pop %0d", k));
    end
    check_word("b status drained", REG_B_STATUS);

    fill_words(3);
    host_write(REG_AR_PUSH, 32'h0);
    n = 0;
    while (got_ar.size() < 1) begin
      if (n == 200) report_timeout("ar handshake");
      @(posedge clk);
      #2;
      n++;
    end
    push_check("ar beat", {2'b01, 4'd2, model_stage[2][2:0], model_stage[1], model_stage[0]},
               got_ar.pop_front());
    send_r({$urandom(), $urandom(), $urandom(), $urandom()}, $urandom_range(0, 15),
           $urandom_range(0, 3));
    check_word("r status", REG_R_STATUS);
    pop_r();
    check_all_words("r pop");
    check_word("r status drained", REG_R_STATUS);

    host_write(REG_LINK_RST_ON, 32'h0);
    wait_link(1'b0, 200);
    host_write(REG_LINK_RST_OFF, 32'h0);
    wait_link(1'b1, 200);

    n = 0;
    while (chk_name.size() > 0) begin
      if (n == 200) report_timeout("pending checks");
      @(posedge clk);
      #2;
      n++;
    end
    if (kernel_i.kernel_asserts_i.assert_fails == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      $display("a bound assertion on the AXI master outputs failed");
      $display("ERRORS FOUND");
      $fatal(1, "assertion failure");
    end
  end

endmodule

// File: verification/kernel_asserts.sv
`timescale 1ns/100ps

module kernel_asserts (
  input logic                              clk,
  input logic                              rstn,
  input logic                              k2o_awvalid,
  input logic                              k2o_awready,
  input logic [kernel_pkg::AXI_ADDR_W-1:0] k2o_awaddr,
  input logic [2:0]                        k2o_awsize,
  input logic [7:0]                        k2o_awlen,
  input logic                              k2o_wvalid,
  input logic                              k2o_wready,
  input logic [kernel_pkg::AXI_DATA_W-1:0] k2o_wdata,
  input logic [kernel_pkg::AXI_STRB_W-1:0] k2o_wstrb,
  input logic                              k2o_wlast,
  input logic                              k2o_arvalid,
  input logic                              k2o_arready,
  input logic [kernel_pkg::AXI_ADDR_W-1:0] k2o_araddr,
  input logic [2:0]                        k2o_arsize,
  input logic [7:0]                        k2o_arlen
);

  int assert_fails = 0;

  aw_hold: assert property (@(posedge clk) disable iff (!rstn)
    k2o_awvalid && !k2o_awready |=> k2o_awvalid && $stable(k2o_awaddr) && $stable(k2o_awsize))
  else begin
    $error("aw valid or payload changed before awready");
    assert_fails++;
  end

  w_hold: assert property (@(posedge clk) disable iff (!rstn)
    k2o_wvalid && !k2o_wready |=> k2o_wvalid && $stable(k2o_wdata) && $stable(k2o_wstrb))
  else begin
    $error("w valid or payload changed before wready");
    assert_fails++;
  end

  ar_hold: assert property (@(posedge clk) disable iff (!rstn)
    k2o_arvalid && !k2o_arready |=> k2o_arvalid && $stable(k2o_araddr) && $stable(k2o_arsize))
  else begin
    $error("ar valid or payload changed before arready");
    assert_fails++;
  end

  single_beat: assert property (@(posedge clk) disable iff (!rstn)
    (k2o_awvalid |-> k2o_awlen == 8'd0) and (k2o_arvalid |-> k2o_arlen == 8'd0)
    and (k2o_wvalid |-> k2o_wlast))
  else begin
    $error("burst length not zero or wlast low on a write beat");
    assert_fails++;
  end

endmodule

bind kernel kernel_asserts kernel_asserts_i (.*);

// File: src/kernel.sv
`timescale 1ns/100ps

module kernel #(
  parameter int fifo_log2_depth = 9
) (
  input  logic                               clk,
  input  logic                               rstn,
  output logic                               link_rstn,
  input  logic                               host_en,
  input  logic [3:0]                         host_we,
  input  logic [kernel_pkg::HOST_ADDR_W-1:0] host_addr,
  input  logic [kernel_pkg::HOST_DATA_W-1:0] host_din,
  output logic [kernel_pkg::HOST_DATA_W-1:0] host_dout,
  output logic [kernel_pkg::AXI_ADDR_W-1:0]  k2o_awaddr,
  output logic [2:0]                         k2o_awsize,
  output logic [kernel_pkg::AXI_ID_W-1:0]    k2o_awid,
  output logic [7:0]                         k2o_awlen,
  output logic [1:0]                         k2o_awburst,
  output logic                               k2o_awvalid,
  input  logic                               k2o_awready,
  output logic [kernel_pkg::AXI_DATA_W-1:0]  k2o_wdata,
  output logic [kernel_pkg::AXI_STRB_W-1:0]  k2o_wstrb,
  output logic                               k2o_wlast,
  output logic                               k2o_wvalid,
  input  logic                               k2o_wready,
  input  logic [kernel_pkg::AXI_ID_W-1:0]    k2o_bid,
  input  logic [1:0]                         k2o_bresp,
  input  logic                               k2o_bvalid,
  output logic                               k2o_bready,
  output logic [kernel_pkg::AXI_ADDR_W-1:0]  k2o_araddr,
  output logic [2:0]                         k2o_arsize,
  output logic [kernel_pkg::AXI_ID_W-1:0]    k2o_arid,
  output logic [7:0]                         k2o_arlen,
  output logic [1:0]                         k2o_arburst,
  output logic                               k2o_arvalid,
  input  logic                               k2o_arready,
  input  logic [kernel_pkg::AXI_DATA_W-1:0]  k2o_rdata,
  input  logic [kernel_pkg::AXI_ID_W-1:0]    k2o_rid,
  input  logic [1:0]                         k2o_rresp,
  input  logic                               k2o_rlast,
  input  logic                               k2o_rvalid,
  output logic                               k2o_rready
);

  import kernel_pkg::*;

  logic      aw_push_valid;
  aw_entry_t aw_push_data;
  logic      w_push_valid;
  w_entry_t  w_push_data;
  logic      ar_push_valid;
  ar_entry_t ar_push_data;
  logic      b_head_valid;
  b_entry_t  b_head;
  logic      b_pop_ready;
  logic      r_head_valid;
  r_entry_t  r_head;
  logic      r_pop_ready;

  host_regs host_regs_i (
    .clk(clk), .rstn(rstn),
    .host_en(host_en), .host_we(host_we), .host_addr(host_addr),
    .host_din(host_din), .host_dout(host_dout),
    .aw_push_valid(aw_push_valid), .aw_push_data(aw_push_data),
    .w_push_valid(w_push_valid), .w_push_data(w_push_data),
    .ar_push_valid(ar_push_valid), .ar_push_data(ar_push_data),
    .b_head_valid(b_head_valid), .b_head(b_head), .b_pop_ready(b_pop_ready),
    .r_head_valid(r_head_valid), .r_head(r_head), .r_pop_ready(r_pop_ready),
    .link_rstn(link_rstn)
  );

  // push ready left open, a full queue drops the host push
  axi_write_master #(.fifo_log2_depth(fifo_log2_depth)) write_master_i (
    .clk(clk), .rstn(rstn),
    .aw_push_valid(aw_push_valid), .aw_push_data(aw_push_data), .aw_push_ready(),
    .w_push_valid(w_push_valid), .w_push_data(w_push_data), .w_push_ready(),
    .b_head_valid(b_head_valid), .b_head(b_head), .b_pop_ready(b_pop_ready),
    .awaddr(k2o_awaddr), .awsize(k2o_awsize), .awid(k2o_awid),
    .awlen(k2o_awlen), .awburst(k2o_awburst),
    .awvalid(k2o_awvalid), .awready(k2o_awready),
    .wdata(k2o_wdata), .wstrb(k2o_wstrb), .wlast(k2o_wlast),
    .wvalid(k2o_wvalid), .wready(k2o_wready),
    .bid(k2o_bid), .bresp(k2o_bresp), .bvalid(k2o_bvalid), .bready(k2o_bready)
  );

  axi_read_master #(.fifo_log2_depth(fifo_log2_depth)) read_master_i (
    .clk(clk), .rstn(rstn),
    .ar_push_valid(ar_push_valid), .ar_push_data(ar_push_data), .ar_push_ready(),
    .r_head_valid(r_head_valid), .r_head(r_head), .r_pop_ready(r_pop_ready),
    .araddr(k2o_araddr), .arsize(k2o_arsize), .arid(k2o_arid),
    .arlen(k2o_arlen), .arburst(k2o_arburst),
    .arvalid(k2o_arvalid), .arready(k2o_arready),
    .rdata(k2o_rdata), .rid(k2o_rid), .rresp(k2o_rresp), .rlast(k2o_rlast),
    .rvalid(k2o_rvalid), .rready(k2o_rready)
  );

endmodule

// File: src/axi_read_master.sv
`timescale 1ns/100ps

module axi_read_master #(
  parameter int fifo_log2_depth = 9
) (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic                              ar_push_valid,
  input  kernel_pkg::ar_entry_t             ar_push_data,
  output logic                              ar_push_ready,
  output logic                              r_head_valid,
  output kernel_pkg::r_entry_t              r_head,
  input  logic                              r_pop_ready,
  output logic [kernel_pkg::AXI_ADDR_W-1:0] araddr,
  output logic [2:0]                        arsize,
  output logic [kernel_pkg::AXI_ID_W-1:0]   arid,
  output logic [7:0]                        arlen,
  output logic [1:0]                        arburst,
  output logic                              arvalid,
  input  logic                              arready,
  input  logic [kernel_pkg::AXI_DATA_W-1:0] rdata,
  input  logic [kernel_pkg::AXI_ID_W-1:0]   rid,
  input  logic [1:0]                        rresp,
  input  logic                              rlast, // every burst is one beat
  input  logic                              rvalid,
  output logic                              rready
);

  import kernel_pkg::*;

  ar_entry_t ar_head;
  r_entry_t  r_beat;

  payload_fifo #(.fifo_log2_depth(fifo_log2_depth), .entry_t(ar_entry_t)) ar_fifo_i (
    .clk(clk), .rstn(rstn),
    .wvalid(ar_push_valid), .wdata(ar_push_data), .wready(ar_push_ready),
    .rvalid(arvalid), .rdata(ar_head), .rready(arready)
  );

  payload_fifo #(.fifo_log2_depth(fifo_log2_depth), .entry_t(r_entry_t)) r_fifo_i (
    .clk(clk), .rstn(rstn),
    .wvalid(rvalid), .wdata(r_beat), .wready(rready),
    .rvalid(r_head_valid), .rdata(r_head), .rready(r_pop_ready)
  );

  assign araddr  = ar_head.addr;
  assign arsize  = ar_head.size;
  assign arid    = AR_ID;
  assign arlen   = 8'd0;
  assign arburst = BURST_INCR;

  assign r_beat.id   = rid;
  assign r_beat.resp = rresp;
  assign r_beat.data = rdata;

endmodule

// File: src/axi_write_master.sv
`timescale 1ns/100ps

module axi_write_master #(
  parameter int fifo_log2_depth = 9
) (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic                              aw_push_valid,
  input  kernel_pkg::aw_entry_t             aw_push_data,
  output logic                              aw_push_ready,
  input  logic                              w_push_valid,
  input  kernel_pkg::w_entry_t              w_push_data,
  output logic                              w_push_ready,
  output logic                              b_head_valid,
  output kernel_pkg::b_entry_t              b_head,
  input  logic                              b_pop_ready,
  output logic [kernel_pkg::AXI_ADDR_W-1:0] awaddr,
  output logic [2:0]                        awsize,
  output logic [kernel_pkg::AXI_ID_W-1:0]   awid,
  output logic [7:0]                        awlen,
  output logic [1:0]                        awburst,
  output logic                              awvalid,
  input  logic                              awready,
  output logic [kernel_pkg::AXI_DATA_W-1:0] wdata,
  output logic [kernel_pkg::AXI_STRB_W-1:0] wstrb,
  output logic                              wlast,
  output logic                              wvalid,
  input  logic                              wready,
  input  logic [kernel_pkg::AXI_ID_W-1:0]   bid,
  input  logic [1:0]                        bresp,
  input  logic                              bvalid,
  output logic                              bready
);

  import kernel_pkg::*;

  aw_entry_t aw_head;
  w_entry_t  w_head;
  b_entry_t  b_beat;

  payload_fifo #(.fifo_log2_depth(fifo_log2_depth), .entry_t(aw_entry_t)) aw_fifo_i (
    .clk(clk), .rstn(rstn),
    .wvalid(aw_push_valid), .wdata(aw_push_data), .wready(aw_push_ready),
    .rvalid(awvalid), .rdata(aw_head), .rready(awready)
  );

  payload_fifo #(.fifo_log2_depth(fifo_log2_depth), .entry_t(w_entry_t)) w_fifo_i (
    .clk(clk), .rstn(rstn),
    .wvalid(w_push_valid), .wdata(w_push_data), .wready(w_push_ready),
    .rvalid(wvalid), .rdata(w_head), .rready(wready)
  );

  payload_fifo #(.fifo_log2_depth(fifo_log2_depth), .entry_t(b_entry_t)) b_fifo_i (
    .clk(clk), .rstn(rstn),
    .wvalid(bvalid), .wdata(b_beat), .wready(bready),
    .rvalid(b_head_valid), .rdata(b_head), .rready(b_pop_ready)
  );

  assign awaddr  = aw_head.addr;
  assign awsize  = aw_head.size;
  assign awid    = AW_ID;
  assign awlen   = 8'd0; // single beat
  assign awburst = BURST_INCR;

  assign wdata = w_head.data;
  assign wstrb = w_head.strb;
  assign wlast = 1'b1;

  assign b_beat.id   = bid;
  assign b_beat.resp = bresp;

endmodule

// File: src/host_regs.sv
`timescale 1ns/100ps

module host_regs (
  input  logic                               clk,
  input  logic                               rstn,
  input  logic                               host_en,
  input  logic [3:0]                         host_we,
  input  logic [kernel_pkg::HOST_ADDR_W-1:0] host_addr,
  input  logic [kernel_pkg::HOST_DATA_W-1:0] host_din,
  output logic [kernel_pkg::HOST_DATA_W-1:0] host_dout,
  output logic                               aw_push_valid,
  output kernel_pkg::aw_entry_t              aw_push_data,
  output logic                               w_push_valid,
  output kernel_pkg::w_entry_t               w_push_data,
  output logic                               ar_push_valid,
  output kernel_pkg::ar_entry_t              ar_push_data,
  input  logic                               b_head_valid,
  input  kernel_pkg::b_entry_t               b_head,
  output logic                               b_pop_ready,
  input  logic                               r_head_valid,
  input  kernel_pkg::r_entry_t               r_head,
  output logic                               r_pop_ready,
  output logic                               link_rstn
);

  import kernel_pkg::*;

  staging_t   stage;
  logic       host_wr;
  logic       host_rd;
  logic       word_hit;
  logic [2:0] word_sel;
  logic       link_sw;

  assign host_wr  = host_en && (host_we != 4'b0);
  assign host_rd  = host_en && (host_we == 4'b0);
  assign word_hit = (host_addr[HOST_ADDR_W-1:5] == REG_DATA0[HOST_ADDR_W-1:5]) &&
                    (host_addr[1:0] == 2'b00);
  assign word_sel = host_addr[4:2];

  // pushes fire during the write cycle, no back-pressure to the host
  assign aw_push_valid = host_wr && (host_addr == REG_AW_PUSH);
  assign w_push_valid  = host_wr && (host_addr == REG_W_PUSH);
  assign ar_push_valid = host_wr && (host_addr == REG_AR_PUSH);

  assign aw_push_data.addr = stage[1:0]; // words 0 and 1
  assign aw_push_data.size = stage[2][2:0];
  assign ar_push_data.addr = stage[1:0];
  assign ar_push_data.size = stage[2][2:0];
  assign w_push_data.data  = stage[3:0]; // words 0 to 3
  assign w_push_data.strb  = stage[4][AXI_STRB_W-1:0];

  assign b_pop_ready = host_wr && (host_addr == REG_B_POP);
  assign r_pop_ready = host_wr && (host_addr == REG_R_POP);

  always_ff @(posedge clk) begin
    if (host_wr && word_hit) begin
      stage[word_sel] <= host_din;
    end else if (b_pop_ready) begin
      stage <= '0; // zero extend the popped entry
      stage[0][AXI_ID_W+1:0] <= {b_head.id, b_head.resp};
    end else if (r_pop_ready) begin
      stage <= '0;
      stage[3:0] <= r_head.data;
      stage[4][AXI_ID_W+1:0] <= {r_head.id, r_head.resp};
    end
  end

  // one cycle read latency, holds otherwise
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      host_dout <= '0;
    end else if (host_rd) begin
      if (word_hit) begin
        host_dout <= stage[word_sel];
      end else if (host_addr == REG_B_STATUS) begin
        host_dout <= HOST_DATA_W'(b_head_valid);
      end else if (host_addr == REG_R_STATUS) begin
        host_dout <= HOST_DATA_W'(r_head_valid);
      end
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      link_sw   <= 1'b1;
      link_rstn <= 1'b0; // held in reset with the kernel
    end else begin
      link_rstn <= link_sw;
      if (host_wr && (host_addr == REG_LINK_RST_ON)) begin
        link_sw <= 1'b0;
      end else if (host_wr && (host_addr == REG_LINK_RST_OFF)) begin
        link_sw <= 1'b1;
      end
    end
  end

endmodule

// File: src/payload_fifo.sv
`timescale 1ns/100ps

module payload_fifo #(
  parameter int  fifo_log2_depth = 9,
  parameter type entry_t         = logic
) (
  input  logic   clk,
  input  logic   rstn,
  input  logic   wvalid,
  input  entry_t wdata,
  output logic   wready,
  output logic   rvalid,
  output entry_t rdata,
  input  logic   rready
);

  localparam int DEPTH = 1 << fifo_log2_depth;

  entry_t                     mem [DEPTH];
  logic [fifo_log2_depth-1:0] wptr;
  logic [fifo_log2_depth-1:0] rptr;
  logic [fifo_log2_depth:0]   count;
  logic                       push;
  logic                       pop;

  assign wready = ~count[fifo_log2_depth]; // msb set only when full
  assign rvalid = count != '0;
  assign rdata  = mem[rptr]; // show-ahead head
  assign push   = wvalid & wready;
  assign pop    = rvalid & rready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wptr] <= wdata;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wptr <= wptr + 1'b1; // wraps at depth
      end
      if (pop) begin
        rptr <= rptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // idle or push with pop
      endcase
    end
  end

endmodule

// File: src/kernel_pkg.sv
package kernel_pkg;

  localparam int HOST_ADDR_W = 15;
  localparam int HOST_DATA_W = 32;
  localparam int AXI_ADDR_W  = 64;
  localparam int AXI_DATA_W  = 128;
  localparam int AXI_STRB_W  = 16;
  localparam int AXI_ID_W    = 4;

  typedef logic [7:0][HOST_DATA_W-1:0] staging_t; // word 0 lowest

  typedef struct packed {
    logic [2:0]            size;
    logic [AXI_ADDR_W-1:0] addr;
  } aw_entry_t;

  typedef aw_entry_t ar_entry_t; // same layout as aw

  typedef struct packed {
    logic [AXI_STRB_W-1:0] strb;
    logic [AXI_DATA_W-1:0] data;
  } w_entry_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0] id;
    logic [1:0]          resp;
  } b_entry_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0]   id;
    logic [1:0]            resp;
    logic [AXI_DATA_W-1:0] data;
  } r_entry_t;

  localparam logic [HOST_ADDR_W-1:0] REG_DATA0        = 15'h000;
  localparam logic [HOST_ADDR_W-1:0] REG_AW_PUSH      = 15'h020;
  localparam logic [HOST_ADDR_W-1:0] REG_W_PUSH       = 15'h030;
  localparam logic [HOST_ADDR_W-1:0] REG_AR_PUSH      = 15'h040;
  localparam logic [HOST_ADDR_W-1:0] REG_B_STATUS     = 15'h050;
  localparam logic [HOST_ADDR_W-1:0] REG_B_POP        = 15'h054;
  localparam logic [HOST_ADDR_W-1:0] REG_R_STATUS     = 15'h060;
  localparam logic [HOST_ADDR_W-1:0] REG_R_POP        = 15'h064;
  localparam logic [HOST_ADDR_W-1:0] REG_LINK_RST_ON  = 15'h0c0;
  localparam logic [HOST_ADDR_W-1:0] REG_LINK_RST_OFF = 15'h0c4;

  localparam logic [AXI_ID_W-1:0] AW_ID      = 4'd1;
  localparam logic [AXI_ID_W-1:0] AR_ID      = 4'd2;
  localparam logic [1:0]          BURST_INCR = 2'b01;

endpackage
